//--- vlog.f
+incdir+hw
+incdir+verification
hw/main_game_pkg.sv
hw/main_bus_pkg.sv
hw/main_addr_decode.sv
hw/main_rom_map.sv
hw/main_io_ports.sv
hw/main_bus.sv
verification/main_bus_tb.sv

//--- Makefile
# Verilator build and run for the main bus testbench

VERILATOR ?= verilator
TOP       ?= main_bus_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= TESTS PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal; the status comes from the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/main_bus_tests.svh
`ifndef MAIN_BUS_TESTS_SVH
`define MAIN_BUS_TESTS_SVH

// Inputs change on the falling edge, outputs are sampled 1 ns later
task automatic bus_access(input logic [15:0] a, input logic we, input int hold);
    @(negedge clk);
    addr   = a;
    cpu_we = we;
    repeat (hold) @(negedge clk);
    #1;
endtask

// One full bus cycle ending with cpu_cen
task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
    @(negedge clk);
    addr     = a;
    cpu_we   = 1'b1;
    cpu_dout = d;
    cpu_cen  = 1'b1;
    @(negedge clk);
    cpu_cen  = 1'b0;
    cpu_we   = 1'b0;
    #1;
endtask

task automatic pulse_cen();
    @(negedge clk);
    cpu_cen = 1'b1;
    @(negedge clk);
    cpu_cen = 1'b0;
    #1;
endtask

task automatic set_game(input game_t g);
    @(negedge clk);
    game = g;
endtask

task automatic wait_dtack();
    int n;
    n = 0;
    #1;
    while (dtack !== 1'b1 && n < TIMEOUT_CYCLES) begin
        @(negedge clk);
        #1;
        n++;
    end
    if (dtack !== 1'b1) begin
        errors++;
        $display("Timed out at %0t ns waiting for dtack to return high", $time);
    end
endtask

task automatic wait_irq(input logic level);
    int n;
    n = 0;
    while (snd_irq !== level && n < TIMEOUT_CYCLES) begin
        @(negedge clk);
        #1;
        n++;
    end
    if (snd_irq !== level) begin
        errors++;
        $display("Timed out at %0t ns waiting for snd_irq to become %0b", $time, level);
    end
endtask

// Aliens inputs by addr[3:0]
function automatic logic [7:0] aliens_port(input int r);
    case (r)
        0: return {dip_pause, 2'b11, service, dipsw[19:16]};
        1: return {cab_1p[0], coin[0], joystick1[5:0]};
        2: return {cab_1p[1], coin[1], joystick2[5:0]};
        3: return dipsw[15:8];
        4: return dipsw[7:0];
        default: return 8'hff;
    endcase
endfunction

// Super Contra inputs at 1F90 + r
function automatic logic [7:0] scontra_port(input int r);
    case (r)
        0: return {dip_pause, 2'b11, cab_1p[1:0], service, coin[1:0]};
        1: return {2'b11, joystick1[5:0]};
        2: return {2'b11, joystick2[5:0]};
        3: return {2'b11, joystick1[6], joystick2[6], dipsw[19:16]};
        4: return dipsw[7:0];
        default: return dipsw[15:8];
    endcase
endfunction

// Each bank is one 8 KB page counted from the bottom of the ROM
function automatic logic [17:0] sc_window_addr(input logic [3:0] bk, input logic [12:0] off);
    return {1'b0, bk, off};
endfunction

task automatic test_reset_state();
    int e;
    e = errors;
    bus_access(16'h8000, 1'b0, 0);
    compare(32'({init, rmrd, work, prio, snd_irq}), 32'd0, "control outputs after reset");
    compare(32'(snd_latch), 32'd0, "sound latch after reset");
    bus_access(16'h8000, 1'b0, 3);
    compare(32'(rom_cs), 32'd0, "rom_cs while rst8 held");
    @(negedge clk);
    rst8 = 1'b0;
    #1;
    compare(32'(rom_cs), 32'd0, "rom_cs right after rst8 falls");
    bus_access(16'h8000, 1'b0, 0);
    compare(32'({rom_cs, dtack}), 32'b11, "rom_cs once reset is over");
    end_test("reset state", e);
endtask

task automatic test_decode();
    int e;
    e = errors;
    bus_access(16'h8000, 1'b0, 0);
    compare(32'({rom_cs, tilesys_cs, objsys_cs}), 32'b100, "aliens 8000");
    bus_access(16'h4000, 1'b0, 0);
    compare(32'({rom_cs, tilesys_cs, objsys_cs}), 32'b010, "aliens 4000 before init");
    bus_write(16'h5f88, 8'h80);                  // init only
    bus_access(16'h5f80, 1'b0, 0);
    compare(32'({rom_cs, tilesys_cs, objsys_cs}), 32'b000, "aliens 5f80 io region");
    bus_access(16'h4000, 1'b0, 0);
    compare(32'({rom_cs, tilesys_cs, objsys_cs}), 32'b010, "aliens 4000 after init");
    bus_access(16'h7c00, 1'b0, 0);
    compare(32'({rom_cs, tilesys_cs, objsys_cs}), 32'b001, "aliens 7c00 objects");
    bus_write(16'h5f88, 8'ha0);                  // init and work
    bus_access(16'h0200, 1'b1, 0);
    compare(32'({pal_we, ram_we}), 32'b10, "aliens 0200 palette with work");
    bus_access(16'h0400, 1'b1, 0);
    compare(32'({pal_we, ram_we}), 32'b01, "aliens 0400 ram with work");
    bus_write(16'h5f88, 8'h80);
    bus_access(16'h0200, 1'b1, 0);
    compare(32'({pal_we, ram_we}), 32'b01, "aliens 0200 ram without work");
    set_game(GAME_SCONTRA);
    bus_write(16'h1f9c, 8'h00);
    bus_access(16'h6000, 1'b0, 0);
    compare(32'({rom_cs, tilesys_cs}), 32'b01, "scontra 6000 before init");
    bus_write(16'h1f9c, 8'h01);
    bus_access(16'h6000, 1'b0, 0);
    compare(32'({rom_cs, tilesys_cs}), 32'b10, "scontra 6000 banked window");
    bus_access(16'h1f80, 1'b0, 0);
    compare(32'({rom_cs, tilesys_cs, objsys_cs}), 32'b000, "scontra 1f80 io region");
    bus_access(16'h1000, 1'b0, 0);
    compare(32'({rom_cs, tilesys_cs, objsys_cs}), 32'b010, "scontra 1000 tiles");
    end_test("chip select decode", e);
endtask

task automatic test_rom_map();
    int          e;
    int          i;
    logic [7:0]  up;
    logic [12:0] off;
    logic [15:0] a;
    logic [3:0]  bk;
    e   = errors;
    up  = 8'(take_bits(8));
    off = 13'(take_bits(13));
    set_game(GAME_ALIENS);
    addr_upper = up;
    bus_access({3'b001, off}, 1'b0, 0);
    compare(32'(rom_cs), 32'd1, "aliens banked window selects rom");
    compare(32'(rom_addr), 32'({up[4:0], off}), "aliens banked rom address");
    a = {1'b1, 15'(take_bits(15))};
    bus_access(a, 1'b0, 0);
    compare(32'(rom_addr), 32'({2'b10, a}), "aliens fixed rom address");
    bus_access({3'b001, off}, 1'b1, 0);
    compare(32'(rom_addr[15:0]), 32'({3'b001, off}), "aliens pass-through, rom_cs low");
    set_game(GAME_SCONTRA);
    bus_write(16'h1f9c, 8'h01);
    for (i = 0; i < 3; i++) begin
        bk  = 4'(take_bits(4));
        off = 13'(take_bits(13));
        bus_write(16'h1f80, {4'h0, bk});         // prio and work stay 0
        bus_access({3'b011, off}, 1'b0, 0);
        compare(32'(rom_addr), 32'(sc_window_addr(bk, off)),
                $sformatf("scontra bank %0h rom address", bk));
    end
    a = {1'b1, 15'(take_bits(15))};
    bus_access(a, 1'b0, 0);
    compare(32'(rom_addr), 32'({2'b00, a}), "scontra fixed rom address");
    bus_access({3'b011, off}, 1'b1, 0);
    compare(32'(rom_addr[15:0]), 32'({3'b011, off}), "scontra pass-through, rom_cs low");
    // Slow ROM holds the CPU
    @(negedge clk);
    rom_ok = 1'b0;
    addr   = 16'h1000;
    cpu_we = 1'b0;
    #1;
    compare(32'(dtack), 32'd1, "dtack high without rom access");
    bus_access(a, 1'b0, 2);
    compare(32'({dtack, rom_addr}), 32'({1'b0, 2'b00, a}), "dtack low while rom_ok low");
    @(negedge clk);
    rom_ok = 1'b1;
    wait_dtack();
    end_test("rom address and banking", e);
endtask

task automatic test_ports();
    int e;
    int r;
    e = errors;
    set_game(GAME_ALIENS);
    joystick1 = 7'(take_bits(7));
    joystick2 = 7'(take_bits(7));
    coin      = 4'(take_bits(4));
    cab_1p    = 4'(take_bits(4));
    service   = 1'(take_bits(1));
    dipsw     = 20'(take_bits(20));
    dip_pause = 1'(take_bits(1));
    for (r = 0; r < 6; r++) begin
        bus_access(16'h5f80 + 16'(r), 1'b0, 2);
        compare(32'(cpu_din), 32'(aliens_port(r)), $sformatf("aliens port %0d", r));
    end
    set_game(GAME_SCONTRA);
    for (r = 0; r < 6; r++) begin
        bus_access(16'h1f90 + 16'(r), 1'b0, 2);
        compare(32'(cpu_din), 32'(scontra_port(r)), $sformatf("scontra port %0d", r));
    end
    end_test("input ports", e);
endtask

task automatic test_sound();
    int         e;
    logic [7:0] d;
    e = errors;
    d = 8'(take_bits(8));
    set_game(GAME_ALIENS);
    bus_write(16'h5f8c, d);
    wait_irq(1'b1);
    compare(32'(snd_latch), 32'(d), "aliens sound latch");
    bus_access(16'h8000, 1'b0, 2);
    compare(32'(snd_irq), 32'd1, "aliens irq held until next cycle");
    pulse_cen();
    compare(32'(snd_irq), 32'd0, "aliens irq cleared by cpu_cen");
    d = 8'(take_bits(8));
    set_game(GAME_SCONTRA);
    bus_write(16'h1f84, d);
    compare(32'({snd_irq, snd_latch}), 32'({1'b0, d}), "scontra latch write");
    bus_write(16'h1f88, 8'h00);
    wait_irq(1'b1);
    pulse_cen();
    compare(32'(snd_irq), 32'd0, "scontra irq cleared by cpu_cen");
    end_test("sound latch and irq", e);
endtask

task automatic test_read_steering();
    int e;
    e = errors;
    set_game(GAME_ALIENS);
    rom_data     = 8'(take_bits(8));
    ram_dout     = 8'(take_bits(8));
    pal_dout     = 8'(take_bits(8));
    tilesys_dout = 8'(take_bits(8));
    objsys_dout  = 8'(take_bits(8));
    bus_write(16'h5f88, 8'ha0);
    bus_access(16'h8000, 1'b0, 0);
    compare(32'(cpu_din), 32'(rom_data), "rom read data");
    bus_access(16'h0400, 1'b0, 0);
    compare(32'(cpu_din), 32'(ram_dout), "ram read data");
    bus_access(16'h0100, 1'b0, 0);
    compare(32'(cpu_din), 32'(pal_dout), "palette read data");
    bus_access(16'h4000, 1'b0, 0);
    compare(32'(cpu_din), 32'(tilesys_dout), "tile read data");
    bus_access(16'h7c00, 1'b0, 0);
    compare(32'(cpu_din), 32'(objsys_dout), "object read data");
    bus_write(16'h5f88, 8'h00);                  // Tiles cover the io page again
    bus_access(16'h5f80, 1'b0, 2);
    compare(32'({tilesys_cs, cpu_din}), 32'({1'b1, aliens_port(0)}), "io over tiles");
    bus_access(16'h9000, 1'b1, 0);
    compare(32'(cpu_din), 32'h0ff, "open bus");
    end_test("read steering", e);
endtask

`endif

//--- verification/main_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "main_macros.svh"

module main_bus_tb;
    import main_game_pkg::*;

    localparam int TIMEOUT_CYCLES = 20;
    localparam int SIM_LIMIT_NS   = 200000;

    logic                    clk = 1'b0;
    logic                    rst, rst8;
    game_t                   game;
    logic [`MAIN_AW-1:0]     addr;
    logic [7:0]              addr_upper;
    logic                    cpu_we, cpu_cen, rom_ok, dtack;
    logic [`MAIN_DW-1:0]     cpu_dout, cpu_din, rom_data, ram_dout;
    logic [`MAIN_DW-1:0]     pal_dout, tilesys_dout, objsys_dout;
    logic                    rom_cs, ram_we, pal_we, tilesys_cs, objsys_cs;
    logic [`MAIN_ROM_AW-1:0] rom_addr;
    logic [3:0]              cab_1p, coin;
    logic [6:0]              joystick1, joystick2;
    logic                    service, dip_pause;
    logic [`MAIN_DIPW-1:0]   dipsw;
    logic                    init, rmrd, work, snd_irq;
    logic [1:0]              prio;
    logic [`MAIN_DW-1:0]     snd_latch;

    int          checks = 0;
    int          errors = 0;
    logic [23:0] lfsr_state = 24'd70276;

    main_bus main_bus_i (.*);

    always #10 clk = ~clk;

    // 24-bit Fibonacci LFSR, taps 24 23 22 17, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[22:0],
                          lfsr_state[23] ^ lfsr_state[22] ^ lfsr_state[21] ^ lfsr_state[16]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    `include "main_bus_tests.svh"

    initial begin
        rst          = 1'b1;
        rst8         = 1'b1;
        game         = GAME_ALIENS;
        addr         = 16'h8000;
        addr_upper   = 8'h00;
        cpu_we       = 1'b0;
        cpu_dout     = 8'h00;
        cpu_cen      = 1'b0;
        rom_ok       = 1'b1;
        rom_data     = 8'h00;
        ram_dout     = 8'h00;
        pal_dout     = 8'h00;
        tilesys_dout = 8'h00;
        objsys_dout  = 8'h00;
        cab_1p       = 4'h0;
        coin         = 4'h0;
        joystick1    = 7'h00;
        joystick2    = 7'h00;
        service      = 1'b0;
        dipsw        = '0;
        dip_pause    = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;                  // rst8 stays high into the first test
        test_reset_state();
        test_decode();
        test_rom_map();
        test_ports();
        test_sound();
        test_read_steering();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(SIM_LIMIT_NS);
        $display("Simulation stopped at its time limit before all tests ran");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/main_bus.sv
`timescale 1ns/1ps
`default_nettype none

`include "main_macros.svh"

module main_bus (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rst8,
    input  main_game_pkg::game_t      game,
    // CPU bus
    input  logic [`MAIN_AW-1:0]       addr,
    input  logic [7:0]                addr_upper,
    input  logic                      cpu_we,
    input  logic [`MAIN_DW-1:0]       cpu_dout,
    input  logic                      cpu_cen,
    output logic [`MAIN_DW-1:0]       cpu_din,
    output logic                      dtack,
    // Memories and video
    output logic                      rom_cs,
    output logic [`MAIN_ROM_AW-1:0]   rom_addr,
    input  logic [`MAIN_DW-1:0]       rom_data,
    input  logic                      rom_ok,
    output logic                      ram_we,
    input  logic [`MAIN_DW-1:0]       ram_dout,
    output logic                      pal_we,
    input  logic [`MAIN_DW-1:0]       pal_dout,
    output logic                      tilesys_cs,
    input  logic [`MAIN_DW-1:0]       tilesys_dout,
    output logic                      objsys_cs,
    input  logic [`MAIN_DW-1:0]       objsys_dout,
    // Cabinet
    input  logic [3:0]                cab_1p,
    input  logic [3:0]                coin,
    input  logic [6:0]                joystick1,
    input  logic [6:0]                joystick2,
    input  logic                      service,
    input  logic [`MAIN_DIPW-1:0]     dipsw,
    input  logic                      dip_pause,
    // Control and sound
    output logic                      init,
    output logic                      rmrd,
    output logic                      work,
    output logic [1:0]                prio,
    output logic [`MAIN_DW-1:0]       snd_latch,
    output logic                      snd_irq
);
    logic                io_cs, banked_cs;
    logic [`MAIN_DW-1:0] port_in;
    logic [3:0]          bank;

    main_addr_decode u_decode (
        .clk(clk), .rst(rst), .rst8(rst8), .game(game),
        .addr(addr), .addr_upper(addr_upper), .cpu_we(cpu_we), .rom_ok(rom_ok),
        .init(init), .rmrd(rmrd), .work(work),
        .rom_data(rom_data), .ram_dout(ram_dout), .port_in(port_in),
        .pal_dout(pal_dout), .tilesys_dout(tilesys_dout), .objsys_dout(objsys_dout),
        .rom_cs(rom_cs), .ram_we(ram_we), .pal_we(pal_we), .io_cs(io_cs),
        .banked_cs(banked_cs), .tilesys_cs(tilesys_cs), .objsys_cs(objsys_cs),
        .dtack(dtack), .cpu_din(cpu_din)
    );

    main_rom_map u_rom_map (
        .game(game), .addr(addr), .addr_upper(addr_upper),
        .rom_cs(rom_cs), .banked_cs(banked_cs), .bank(bank),
        .rom_addr(rom_addr)
    );

    main_io_ports u_io (
        .clk(clk), .rst(rst), .game(game),
        .addr(addr), .addr_upper(addr_upper), .cpu_we(cpu_we),
        .cpu_dout(cpu_dout), .cpu_cen(cpu_cen), .io_cs(io_cs),
        .cab_1p(cab_1p), .coin(coin), .joystick1(joystick1), .joystick2(joystick2),
        .service(service), .dipsw(dipsw), .dip_pause(dip_pause),
        .port_in(port_in), .init(init), .rmrd(rmrd), .work(work), .prio(prio),
        .bank(bank), .snd_latch(snd_latch), .snd_irq(snd_irq)
    );

endmodule

`default_nettype wire

//--- hw/main_io_ports.sv
`timescale 1ns/1ps
`default_nettype none

`include "main_macros.svh"

module main_io_ports (
    input  logic                   clk,
    input  logic                   rst,
    input  main_game_pkg::game_t   game,
    input  logic [`MAIN_AW-1:0]    addr,
    input  logic [7:0]             addr_upper,
    input  logic                   cpu_we,
    input  logic [`MAIN_DW-1:0]    cpu_dout,
    input  logic                   cpu_cen,
    input  logic                   io_cs,
    input  logic [3:0]             cab_1p,
    input  logic [3:0]             coin,
    input  logic [6:0]             joystick1,
    input  logic [6:0]             joystick2,
    input  logic                   service,
    input  logic [`MAIN_DIPW-1:0]  dipsw,
    input  logic                   dip_pause,
    output logic [`MAIN_DW-1:0]    port_in,
    output logic                   init,
    output logic                   rmrd,
    output logic                   work,
    output logic [1:0]             prio,
    output logic [3:0]             bank,
    output logic [`MAIN_DW-1:0]    snd_latch,
    output logic                   snd_irq
);
    import main_game_pkg::*;

    logic                 wr_en, rd_en;
    logic [3:0]           ctrl_bank;
    logic [`MAIN_DW-1:0]  rd_value;

    assign wr_en = io_cs && cpu_we && cpu_cen;  // Once per bus cycle
    assign rd_en = io_cs && !cpu_we;

    // Port layout per game
    always_comb begin
        rd_value = 8'hff;
        case (game)
            GAME_SCONTRA: begin
                if (!addr[5]) begin
                    case (addr[4:2])
                        SC_REG_PORTS: begin
                            case (addr[1:0])
                                2'd0: rd_value = {dip_pause, 2'b11, cab_1p[1:0],
                                                  service, coin[1:0]};
                                2'd1: rd_value = {2'b11, joystick1[5:0]};
                                2'd2: rd_value = {2'b11, joystick2[5:0]};
                                default: rd_value = {2'b11, joystick1[6], joystick2[6],
                                                     dipsw[19:16]};
                            endcase
                        end
                        SC_REG_DIPS: rd_value = addr[0] ? dipsw[15:8] : dipsw[7:0];
                        default: rd_value = 8'hff;
                    endcase
                end
            end
            default: begin
                case (addr[3:0])
                    ALIENS_PORT_SYS: rd_value = {dip_pause, 2'b11, service, dipsw[19:16]};
                    ALIENS_PORT_P1:  rd_value = {cab_1p[0], coin[0], joystick1[5:0]};
                    ALIENS_PORT_P2:  rd_value = {cab_1p[1], coin[1], joystick2[5:0]};
                    ALIENS_DIP_HI:   rd_value = dipsw[15:8];
                    ALIENS_DIP_LO:   rd_value = dipsw[7:0];
                    default:         rd_value = 8'hff;
                endcase
            end
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            port_in   <= '0;
            init      <= 1'b0;  // Scroll is garbled if left set
            rmrd      <= 1'b0;
            work      <= 1'b0;
            prio      <= 2'd0;
            ctrl_bank <= 4'd0;
            bank      <= 4'd0;
            snd_latch <= '0;
            snd_irq   <= 1'b0;
        end else begin
            // Only Super Contra latches its bank
            bank <= (game == GAME_SCONTRA) ? ctrl_bank : addr_upper[3:0];
            if (cpu_cen) begin
                snd_irq <= 1'b0;
            end
            if (rd_en) begin
                port_in <= rd_value;
            end
            if (wr_en) begin
                case (game)
                    GAME_SCONTRA: begin
                        if (!addr[5]) begin
                            case (addr[4:2])
                                SC_REG_CTRL: begin
                                    prio              <= {1'b0, cpu_dout[7]};
                                    {work, ctrl_bank} <= cpu_dout[4:0];
                                end
                                SC_REG_SNDL: snd_latch <= cpu_dout;
                                SC_REG_SNDI: snd_irq   <= 1'b1;
                                SC_REG_RMRD: rmrd      <= cpu_dout[0];
                                SC_REG_INIT: init      <= cpu_dout[0];
                                default: ;           // Watchdog and spares
                            endcase
                        end
                    end
                    default: begin
                        case (addr[3:0])
                            ALIENS_CTRL: {init, rmrd, work} <= cpu_dout[7:5];
                            ALIENS_SND: begin
                                snd_latch <= cpu_dout;
                                snd_irq   <= 1'b1;
                            end
                            default: ;
                        endcase
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/main_rom_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "main_macros.svh"

module main_rom_map (
    input  main_game_pkg::game_t      game,
    input  logic [`MAIN_AW-1:0]       addr,
    input  logic [7:0]                addr_upper,
    input  logic                      rom_cs,
    input  logic                      banked_cs,
    input  logic [3:0]                bank,
    output logic [`MAIN_ROM_AW-1:0]   rom_addr
);
    import main_game_pkg::*;

    logic sc_high;

    // Upper half of the Super Contra ROM
    assign sc_high = banked_cs && bank[3];

    always_comb begin
        case (game)
            GAME_SCONTRA: begin
                rom_addr[17]    = 1'b0;
                rom_addr[16]    = sc_high;
                rom_addr[15]    = banked_cs ? bank[2] : addr[15];
                rom_addr[14:13] = banked_cs ? bank[1:0] : addr[14:13];
                rom_addr[12:0]  = addr[12:0];
            end
            default: begin
                // Aliens takes the page register straight from the CPU
                if (banked_cs) begin
                    rom_addr = {addr_upper[4:0], addr[12:0]};
                end else begin
                    rom_addr = {2'b10, addr};     // Fixed code at the top
                end
            end
        endcase
        // Graphics chips share this address bus
        if (!rom_cs) begin
            rom_addr[15:0] = addr;
        end
    end

endmodule

`default_nettype wire

//--- hw/main_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "main_macros.svh"

module main_addr_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rst8,
    input  main_game_pkg::game_t   game,
    input  logic [`MAIN_AW-1:0]    addr,
    input  logic [7:0]             addr_upper,
    input  logic                   cpu_we,
    input  logic                   rom_ok,
    input  logic                   init,
    input  logic                   rmrd,
    input  logic                   work,
    input  logic [`MAIN_DW-1:0]    rom_data,
    input  logic [`MAIN_DW-1:0]    ram_dout,
    input  logic [`MAIN_DW-1:0]    port_in,
    input  logic [`MAIN_DW-1:0]    pal_dout,
    input  logic [`MAIN_DW-1:0]    tilesys_dout,
    input  logic [`MAIN_DW-1:0]    objsys_dout,
    output logic                   rom_cs,
    output logic                   ram_we,
    output logic                   pal_we,
    output logic                   io_cs,
    output logic                   banked_cs,
    output logic                   tilesys_cs,
    output logic                   objsys_cs,
    output logic                   dtack,
    output logic [`MAIN_DW-1:0]    cpu_din
);
    import main_game_pkg::*;
    import main_bus_pkg::*;

    logic    rst_cmb;
    logic    ram_cs, pal_cs;
    logic    a65_zero, a43_zero;
    logic    sc_ioout, sc_incs, sc_chain, sc_objhit;
    region_t rd_region;

    assign a65_zero = addr[6:5] == 2'b00;
    assign a43_zero = addr[4:3] == 2'b00;

    // Super Contra helper terms from the second decoder
    assign sc_ioout  = addr[15:13] == 3'd0;
    assign sc_incs   = !init && addr[15:13] == 3'b011;
    assign sc_chain  = addr[15:12] == 4'b0011 && !rmrd;
    assign sc_objhit = sc_chain && addr[11] && (addr[10] || addr[9:3] == 7'd0);

    // Board reset plus the video reset held over the first frames
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rst_cmb <= 1'b1;
        end else begin
            rst_cmb <= rst8;
        end
    end

    always_comb begin
        banked_cs  = 1'b0;
        ram_cs     = 1'b0;
        io_cs      = 1'b0;
        pal_cs     = 1'b0;
        objsys_cs  = 1'b0;
        tilesys_cs = 1'b0;
        case (game)
            GAME_SCONTRA: begin
                banked_cs  = addr[15:13] == 3'd3 && init;   // 6000-7FFF
                pal_cs     = addr[15:12] == 4'd5 && addr[11] && !work;
                ram_cs     = addr[15:13] == 3'd2 &&
                             (!addr[11] || !addr[12] || work);
                io_cs      = sc_ioout && addr[12:8] == 5'h1f && addr[7];
                objsys_cs  = sc_objhit;
                tilesys_cs = !(!sc_incs && (addr[15:14] != 2'd0 || sc_objhit ||
                               (&addr[12:7] && sc_ioout)));
            end
            default: begin
                banked_cs  = addr[15:13] == 3'd1;           // 2000-3FFF
                ram_cs     = addr[15:13] == 3'd0 && (|addr[12:10] || !work);
                io_cs      = addr[15:7] == 9'b0101_1111_1 && a65_zero;
                pal_cs     = addr[15:10] == 6'd0 && work;
                objsys_cs  = addr[15:11] == 5'b01111 && !rmrd && init &&
                             (addr[10] || (addr[9:7] == 3'd0 && a65_zero && a43_zero));
                // Tile chips see the whole 4000-7FFF page until init
                tilesys_cs = addr[15:14] == 2'd1 &&
                             (!init || (!io_cs && !pal_cs && !objsys_cs));
            end
        endcase
    end

    // ROM only answers reads
    assign rom_cs = !rst_cmb && (addr[15] || banked_cs) && !cpu_we;
    assign ram_we = ram_cs && cpu_we;
    assign pal_we = pal_cs && cpu_we;
    assign dtack  = !rom_cs || rom_ok;   // Stall on slow SDRAM

    // Read priority
    always_comb begin
        if (rom_cs) begin
            rd_region = REG_ROM;
        end else if (ram_cs) begin
            rd_region = REG_RAM;
        end else if (io_cs) begin
            rd_region = REG_IO;
        end else if (pal_cs) begin
            rd_region = REG_PAL;
        end else if (tilesys_cs) begin
            rd_region = REG_TILE;
        end else if (objsys_cs) begin
            rd_region = REG_OBJ;
        end else begin
            rd_region = REG_NONE;
        end
    end

    always_comb begin
        case (rd_region)
            REG_ROM:  cpu_din = rom_data;
            REG_RAM:  cpu_din = ram_dout;
            REG_IO:   cpu_din = port_in;     // Registered one clock earlier
            REG_PAL:  cpu_din = pal_dout;
            REG_TILE: cpu_din = tilesys_dout;
            REG_OBJ:  cpu_din = objsys_dout;
            default:  cpu_din = OPEN_BUS;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/main_bus_pkg.sv
`default_nettype none

package main_bus_pkg;

    // Region that owns the current read cycle.
    // Listed roughly in the order the read mux checks them
    typedef enum logic [2:0] {
        REG_NONE = 3'd0,
        REG_ROM  = 3'd1,
        REG_RAM  = 3'd2,
        REG_IO   = 3'd3, // Must win over the tile region
        REG_PAL  = 3'd4,
        REG_TILE = 3'd5,
        REG_OBJ  = 3'd6
    } region_t;

    // Value seen by the CPU when nobody drives the bus
    localparam logic [7:0] OPEN_BUS = 8'hff;

endpackage

`default_nettype wire

//--- hw/main_game_pkg.sv
`default_nettype none

package main_game_pkg;

    typedef enum logic [1:0] {
        GAME_ALIENS  = 2'd0,
        GAME_SCONTRA = 2'd1
    } game_t;

    // Aliens I/O map, offsets in addr[3:0]
    localparam logic [3:0] ALIENS_PORT_SYS = 4'h0;
    localparam logic [3:0] ALIENS_PORT_P1  = 4'h1;
    localparam logic [3:0] ALIENS_PORT_P2  = 4'h2;
    localparam logic [3:0] ALIENS_DIP_HI   = 4'h3;
    localparam logic [3:0] ALIENS_DIP_LO   = 4'h4;
    localparam logic [3:0] ALIENS_CTRL     = 4'h8; // init, rmrd, work
    localparam logic [3:0] ALIENS_SND      = 4'hc; // Latch and IRQ together

    // Super Contra I/O map, register index in addr[4:2]
    localparam logic [2:0] SC_REG_CTRL  = 3'd0; // prio, work, bank
    localparam logic [2:0] SC_REG_SNDL  = 3'd1;
    localparam logic [2:0] SC_REG_SNDI  = 3'd2;
    localparam logic [2:0] SC_REG_PORTS = 3'd4; // Cabinet, selected by addr[1:0]
    localparam logic [2:0] SC_REG_DIPS  = 3'd5;
    localparam logic [2:0] SC_REG_RMRD  = 3'd6;
    localparam logic [2:0] SC_REG_INIT  = 3'd7;

endpackage

`default_nettype wire

//--- hw/main_macros.svh
`ifndef MAIN_MACROS_SVH
`define MAIN_MACROS_SVH

// CPU address below the page register
`define MAIN_AW 16

// Program ROM address, 256 KB
`define MAIN_ROM_AW 18

// CPU data bus
`define MAIN_DW 8

// DIP switch bank
`define MAIN_DIPW 20

`endif
